// ==== hdl/hyperbus_defines.svh ====
// Timing and width constants for the HyperBus PHY; include wherever a macro is needed.
`ifndef HYPERBUS_DEFINES_SVH
`define HYPERBUS_DEFINES_SVH

// Clock cycles from the end of command-address to the first data byte.
`define HB_LATENCY_CYCLES 12

// Bytes shifted out during the command-address phase.
`define HB_CA_BYTES 6

// Data word width on the user side.
`define HB_WORD_BITS 16

// Width of the DQ bus.
`define HB_BYTE_BITS 8

// Width of the byte address on the request port.
`define HB_ADDR_BITS 32

`endif

// ==== hdl/hyperbus_pkg.sv ====
// Shared types of the HyperBus PHY; modules take them by a wildcard import.
`include "hyperbus_defines.svh"

package hyperbus_pkg;

  // One user data word and its byte strobes.
  typedef logic [`HB_WORD_BITS-1:0] hb_word_t;
  typedef logic [`HB_WORD_BITS/`HB_BYTE_BITS-1:0] hb_strb_t;

  // Encodings of the command-address control bits.
  localparam logic HB_SPACE_MEM    = 1'b0;
  localparam logic HB_BURST_LINEAR = 1'b1;

  // Command-address word, bit 47 first on the bus.
  typedef struct packed {
    logic        rw;
    logic        addr_space;
    logic        burst_type;
    logic [28:0] upper_addr;
    logic [12:0] reserved;
    logic [2:0]  lower_addr;
  } hb_ca_fields_t;

  // Decode fills the fields, the bus FSM sends the bytes, highest index first.
  typedef union packed {
    hb_ca_fields_t                                fields;
    logic [`HB_CA_BYTES-1:0][`HB_BYTE_BITS-1:0] bytes;
  } hb_ca_t;

endpackage

// ==== hdl/hyperbus_cmd_if.sv ====
// Decoded command channel from request decode to the bus FSM, valid/ready handshake.
interface hyperbus_cmd_if
  import hyperbus_pkg::*;
#(
  parameter int NR_CS       = 2,
  parameter int BURST_WIDTH = 12
) ();

  // Handshake.
  logic                   valid;
  logic                   ready;

  // Command payload, stable while valid is high.
  hb_ca_t                 ca;
  logic [NR_CS-1:0]       cs;
  logic                   write;
  logic [BURST_WIDTH-1:0] burst;

  // Decode side.
  modport producer (
    output valid,
    input  ready,
    output ca,
    output cs,
    output write,
    output burst
  );

  // Bus FSM side.
  modport consumer (
    input  valid,
    output ready,
    input  ca,
    input  cs,
    input  write,
    input  burst
  );

endinterface

// ==== hdl/hyperbus_cmd_decode.sv ====
// Takes one request at a time and turns it into a command-address word for the bus FSM.
`include "hyperbus_defines.svh"

module hyperbus_cmd_decode
  import hyperbus_pkg::*;
#(
  parameter int NR_CS       = 2,
  parameter int BURST_WIDTH = 12
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     trans_valid_i,
  output logic                     trans_ready_o,
  input  logic [`HB_ADDR_BITS-1:0] trans_address_i,
  input  logic [NR_CS-1:0]         trans_cs_i,
  input  logic                     trans_write_i,
  input  logic [BURST_WIDTH-1:0]   trans_burst_i,
  hyperbus_cmd_if.producer         cmd
);

  logic                     full_q;
  logic                     accept;
  logic [`HB_ADDR_BITS-1:0] word_addr;
  hb_ca_t                   ca_d;
  hb_ca_t                   ca_q;
  logic [NR_CS-1:0]         cs_q;
  logic                     write_q;
  logic [BURST_WIDTH-1:0]   burst_q;

  // Only one command is held, so a new request waits until the FSM takes it.
  assign trans_ready_o = ~full_q;
  assign accept        = trans_valid_i & trans_ready_o;

  // The memory is addressed in 16-bit words.
  always_comb begin
    word_addr                = {1'b0, trans_address_i[`HB_ADDR_BITS-1:1]};
    ca_d                     = '0;
    ca_d.fields.rw           = ~trans_write_i;
    ca_d.fields.addr_space   = HB_SPACE_MEM;
    ca_d.fields.burst_type   = HB_BURST_LINEAR;
    ca_d.fields.upper_addr   = word_addr[`HB_ADDR_BITS-1:3];
    ca_d.fields.reserved     = '0;
    ca_d.fields.lower_addr   = word_addr[2:0];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (cmd.valid && cmd.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ca_q    <= ca_d;
      cs_q    <= trans_cs_i;
      write_q <= trans_write_i;
      burst_q <= trans_burst_i;
    end
  end

  assign cmd.valid = full_q;
  assign cmd.ca    = ca_q;
  assign cmd.cs    = cs_q;
  assign cmd.write = write_q;
  assign cmd.burst = burst_q;

endmodule

// ==== hdl/hyperbus_bus_fsm.sv ====
// Drives the HyperBus pins for one command: chip select, clock, command-address, latency, data.
`include "hyperbus_defines.svh"

module hyperbus_bus_fsm
  import hyperbus_pkg::*;
#(
  parameter int NR_CS       = 2,
  parameter int BURST_WIDTH = 12
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  hyperbus_cmd_if.consumer         cmd,
  input  logic                     tx_valid_i,
  output logic                     tx_ready_o,
  input  hb_word_t                 tx_data_i,
  input  hb_strb_t                 tx_strb_i,
  output logic                     rx_byte_valid_o,
  output logic [`HB_BYTE_BITS-1:0] rx_byte_o,
  input  logic                     rx_full_i,
  output logic [NR_CS-1:0]         hyper_cs_no,
  output logic                     hyper_ck_o,
  output logic                     hyper_ck_no,
  output logic                     hyper_rwds_o,
  input  logic                     hyper_rwds_i,
  output logic                     hyper_rwds_oe_o,
  output logic [`HB_BYTE_BITS-1:0] hyper_dq_o,
  input  logic [`HB_BYTE_BITS-1:0] hyper_dq_i,
  output logic                     hyper_dq_oe_o,
  output logic                     hyper_reset_no
);

  localparam int CA_W  = $clog2(`HB_CA_BYTES + 1);
  localparam int LAT_W = $clog2(`HB_LATENCY_CYCLES + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CA,
    ST_LAT,
    ST_WDATA,
    ST_RDATA,
    ST_DONE
  } state_e;

  state_e                   state_q;
  logic                     phase_q;
  logic [CA_W-1:0]          ca_cnt_q;
  logic [LAT_W-1:0]         lat_cnt_q;
  logic [BURST_WIDTH-1:0]   word_cnt_q;
  logic [BURST_WIDTH:0]     rx_cnt_q;
  logic [NR_CS-1:0]         cs_no_q;
  logic                     ck_en_q;
  logic                     ck_q;
  logic                     dq_oe_q;
  logic                     rwds_oe_q;
  logic                     rx_byte_valid_q;
  logic [1:0]               rst_sync_q;
  logic                     words_done;

  hb_ca_t                   ca_q;
  logic                     write_q;
  logic [BURST_WIDTH-1:0]   burst_q;
  logic [`HB_BYTE_BITS-1:0] dq_out_q;
  logic                     rwds_out_q;
  logic [`HB_BYTE_BITS-1:0] lo_byte_q;
  logic                     lo_mask_q;
  logic                     rwds_prev_q;
  logic [`HB_BYTE_BITS-1:0] rx_byte_q;

  assign cmd.ready  = (state_q == ST_IDLE);
  assign words_done = (word_cnt_q == burst_q);

  // Each word slot starts in phase 0, where the write data is taken.
  assign tx_ready_o = (state_q == ST_WDATA) && !phase_q && !words_done;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q         <= ST_IDLE;
      phase_q         <= 1'b0;
      ca_cnt_q        <= '0;
      lat_cnt_q       <= '0;
      word_cnt_q      <= '0;
      rx_cnt_q        <= '0;
      cs_no_q         <= '1;
      ck_en_q         <= 1'b0;
      dq_oe_q         <= 1'b0;
      rwds_oe_q       <= 1'b0;
      rx_byte_valid_q <= 1'b0;
    end else begin
      // A read byte is marked by any change of RWDS.
      rx_byte_valid_q <= (state_q == ST_RDATA) && (hyper_rwds_i != rwds_prev_q);
      if (rx_byte_valid_q) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          if (cmd.valid) begin
            cs_no_q  <= ~cmd.cs;
            ca_cnt_q <= '0;
            rx_cnt_q <= '0;
            state_q  <= ST_CA;
          end
        end
        ST_CA: begin
          ck_en_q  <= 1'b1;
          dq_oe_q  <= 1'b1;
          ca_cnt_q <= ca_cnt_q + 1'b1;
          if (ca_cnt_q == CA_W'(`HB_CA_BYTES - 1)) begin
            lat_cnt_q <= '0;
            state_q   <= ST_LAT;
          end
        end
        ST_LAT: begin
          ck_en_q   <= 1'b1;
          dq_oe_q   <= 1'b0;
          lat_cnt_q <= lat_cnt_q + 1'b1;
          if (lat_cnt_q == LAT_W'(`HB_LATENCY_CYCLES - 1)) begin
            word_cnt_q <= '0;
            phase_q    <= 1'b0;
            state_q    <= write_q ? ST_WDATA : ST_RDATA;
          end
        end
        ST_WDATA: begin
          if (phase_q) begin
            ck_en_q    <= 1'b1;
            phase_q    <= 1'b0;
            word_cnt_q <= word_cnt_q + 1'b1;
          end else if (words_done) begin
            ck_en_q <= 1'b0;
            state_q <= ST_DONE;
          end else if (tx_valid_i) begin
            ck_en_q   <= 1'b1;
            dq_oe_q   <= 1'b1;
            rwds_oe_q <= 1'b1;
            phase_q   <= 1'b1;
          end else begin
            // Clock holds until the next word arrives.
            ck_en_q <= 1'b0;
          end
        end
        ST_RDATA: begin
          if (phase_q) begin
            ck_en_q    <= 1'b1;
            phase_q    <= 1'b0;
            word_cnt_q <= word_cnt_q + 1'b1;
          end else if (words_done) begin
            ck_en_q <= 1'b0;
            if (rx_cnt_q == {burst_q, 1'b0}) begin
              state_q <= ST_DONE;
            end
          end else if (!rx_full_i) begin
            ck_en_q <= 1'b1;
            phase_q <= 1'b1;
          end else begin
            ck_en_q <= 1'b0;
          end
        end
        ST_DONE: begin
          cs_no_q   <= '1;
          ck_en_q   <= 1'b0;
          dq_oe_q   <= 1'b0;
          rwds_oe_q <= 1'b0;
          state_q   <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Bus data and the captured command.
  always_ff @(posedge clk_i) begin
    rwds_prev_q <= hyper_rwds_i;
    rx_byte_q   <= hyper_dq_i;
    if (cmd.valid && cmd.ready) begin
      ca_q    <= cmd.ca;
      write_q <= cmd.write;
      burst_q <= cmd.burst;
    end else if (state_q == ST_CA) begin
      ca_q.bytes <= {ca_q.bytes[`HB_CA_BYTES-2:0], {`HB_BYTE_BITS{1'b0}}};
    end
    if (state_q == ST_CA) begin
      dq_out_q <= ca_q.bytes[`HB_CA_BYTES-1];
    end else if (tx_ready_o && tx_valid_i) begin
      // High byte goes first, RWDS high masks the byte.
      dq_out_q   <= tx_data_i[`HB_WORD_BITS-1:`HB_BYTE_BITS];
      rwds_out_q <= ~tx_strb_i[1];
      lo_byte_q  <= tx_data_i[`HB_BYTE_BITS-1:0];
      lo_mask_q  <= ~tx_strb_i[0];
    end else if ((state_q == ST_WDATA) && phase_q) begin
      dq_out_q   <= lo_byte_q;
      rwds_out_q <= lo_mask_q;
    end
  end

  // Toggling on the falling edge centers each clock edge in its data byte.
  always_ff @(negedge clk_i) begin
    if (!rst_n_i) begin
      ck_q <= 1'b0;
    end else if (ck_en_q) begin
      ck_q <= ~ck_q;
    end
  end

  // Memory reset is released one cycle after the PHY reset.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign hyper_cs_no     = cs_no_q;
  assign hyper_ck_o      = ck_q;
  assign hyper_ck_no     = ~ck_q;
  assign hyper_dq_o      = dq_out_q;
  assign hyper_dq_oe_o   = dq_oe_q;
  assign hyper_rwds_o    = rwds_out_q;
  assign hyper_rwds_oe_o = rwds_oe_q;
  assign hyper_reset_no  = rst_sync_q[1];
  assign rx_byte_valid_o = rx_byte_valid_q;
  assign rx_byte_o       = rx_byte_q;

endmodule

// ==== hdl/hyperbus_rx_assemble.sv ====
// Joins read bytes into 16-bit words and buffers two of them for the rx port.
`include "hyperbus_defines.svh"

module hyperbus_rx_assemble
  import hyperbus_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     rx_byte_valid_i,
  input  logic [`HB_BYTE_BITS-1:0] rx_byte_i,
  output logic                     rx_full_o,
  output logic                     rx_valid_o,
  input  logic                     rx_ready_i,
  output hb_word_t                 rx_data_o
);

  logic                     half_q;
  logic [`HB_BYTE_BITS-1:0] hi_byte_q;
  hb_word_t                 buf_q [2];
  logic                     wr_ptr_q;
  logic                     rd_ptr_q;
  logic [1:0]               count_q;
  logic                     push;
  logic                     pop;
  logic                     pending;
  logic [2:0]               occupancy;

  assign push = rx_byte_valid_i & half_q;
  assign pop  = rx_valid_o & rx_ready_i;

  // A half word or an arriving byte will become a word soon.
  assign pending   = half_q | rx_byte_valid_i;
  assign occupancy = {1'b0, count_q} + {2'b00, pending} - {2'b00, pop};
  assign rx_full_o = (occupancy >= 3'd2);

  assign rx_valid_o = (count_q != 2'd0);
  assign rx_data_o  = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      half_q   <= 1'b0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (rx_byte_valid_i) begin
        half_q <= ~half_q;
      end
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // First byte of a pair is the high byte.
  always_ff @(posedge clk_i) begin
    if (rx_byte_valid_i && !half_q) begin
      hi_byte_q <= rx_byte_i;
    end
    if (push) begin
      buf_q[wr_ptr_q] <= {hi_byte_q, rx_byte_i};
    end
  end

endmodule

// ==== hdl/hyperbus_phy.sv ====
// HyperBus master PHY top level; connect the request, tx, rx ports and the memory pins.
`include "hyperbus_defines.svh"

module hyperbus_phy
  import hyperbus_pkg::*;
#(
  parameter int NR_CS       = 2,
  parameter int BURST_WIDTH = 12
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Transaction requests.
  input  logic                     trans_valid_i,
  output logic                     trans_ready_o,
  input  logic [`HB_ADDR_BITS-1:0] trans_address_i,
  input  logic [NR_CS-1:0]         trans_cs_i,
  input  logic                     trans_write_i,
  input  logic [BURST_WIDTH-1:0]   trans_burst_i,

  // Write data.
  input  logic                     tx_valid_i,
  output logic                     tx_ready_o,
  input  hb_word_t                 tx_data_i,
  input  hb_strb_t                 tx_strb_i,

  // Read data.
  output logic                     rx_valid_o,
  input  logic                     rx_ready_i,
  output hb_word_t                 rx_data_o,

  // Memory pins.
  output logic [NR_CS-1:0]         hyper_cs_no,
  output logic                     hyper_ck_o,
  output logic                     hyper_ck_no,
  output logic                     hyper_rwds_o,
  input  logic                     hyper_rwds_i,
  output logic                     hyper_rwds_oe_o,
  input  logic [`HB_BYTE_BITS-1:0] hyper_dq_i,
  output logic [`HB_BYTE_BITS-1:0] hyper_dq_o,
  output logic                     hyper_dq_oe_o,
  output logic                     hyper_reset_no
);

  logic                     rx_byte_valid;
  logic [`HB_BYTE_BITS-1:0] rx_byte;
  logic                     rx_full;

  hyperbus_cmd_if #(
    .NR_CS       (NR_CS),
    .BURST_WIDTH (BURST_WIDTH)
  ) cmd_if ();

  hyperbus_cmd_decode #(
    .NR_CS       (NR_CS),
    .BURST_WIDTH (BURST_WIDTH)
  ) u_cmd_decode (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trans_valid_i   (trans_valid_i),
    .trans_ready_o   (trans_ready_o),
    .trans_address_i (trans_address_i),
    .trans_cs_i      (trans_cs_i),
    .trans_write_i   (trans_write_i),
    .trans_burst_i   (trans_burst_i),
    .cmd             (cmd_if.producer)
  );

  hyperbus_bus_fsm #(
    .NR_CS       (NR_CS),
    .BURST_WIDTH (BURST_WIDTH)
  ) u_bus_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd             (cmd_if.consumer),
    .tx_valid_i      (tx_valid_i),
    .tx_ready_o      (tx_ready_o),
    .tx_data_i       (tx_data_i),
    .tx_strb_i       (tx_strb_i),
    .rx_byte_valid_o (rx_byte_valid),
    .rx_byte_o       (rx_byte),
    .rx_full_i       (rx_full),
    .hyper_cs_no     (hyper_cs_no),
    .hyper_ck_o      (hyper_ck_o),
    .hyper_ck_no     (hyper_ck_no),
    .hyper_rwds_o    (hyper_rwds_o),
    .hyper_rwds_i    (hyper_rwds_i),
    .hyper_rwds_oe_o (hyper_rwds_oe_o),
    .hyper_dq_o      (hyper_dq_o),
    .hyper_dq_i      (hyper_dq_i),
    .hyper_dq_oe_o   (hyper_dq_oe_o),
    .hyper_reset_no  (hyper_reset_no)
  );

  hyperbus_rx_assemble u_rx_assemble (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rx_byte_valid_i (rx_byte_valid),
    .rx_byte_i       (rx_byte),
    .rx_full_o       (rx_full),
    .rx_valid_o      (rx_valid_o),
    .rx_ready_i      (rx_ready_i),
    .rx_data_o       (rx_data_o)
  );

endmodule

// ==== tests/hyperram_model.sv ====
// Behavioral HyperRAM for the testbench; one instance per chip select, fed by the PHY pins.
`include "hyperbus_defines.svh"

module hyperram_model #(
  parameter logic [15:0] FILL_KEY = 16'h0000
) (
  input  logic                     ck_i,
  input  logic                     cs_ni,
  input  logic [`HB_BYTE_BITS-1:0] dq_i,
  input  logic                     rwds_i,
  output logic [`HB_BYTE_BITS-1:0] dq_o,
  output logic                     rwds_o
);

  // Clock edges before the first data byte.
  localparam int DATA_EDGE = `HB_CA_BYTES + `HB_LATENCY_CYCLES;

  logic [15:0]              mem [logic [31:0]];
  logic [47:0]              ca;
  logic [31:0]              addr;
  logic [`HB_BYTE_BITS-1:0] hi_byte;
  logic                     hi_mask;
  logic [15:0]              word;
  logic                     ck_prev;
  int                       edge_cnt;
  int                       data_idx;

  // Unwritten words hold a pattern built from the whole word address.
  function automatic logic [15:0] read_word(logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a[15:0] ^ a[31:16] ^ FILL_KEY;
  endfunction

  initial begin
    dq_o     = '0;
    rwds_o   = 1'b0;
    ck_prev  = 1'b0;
    edge_cnt = 0;
  end

  // Every change of CK moves one byte while the chip is selected.
  always @(ck_i or cs_ni) begin
    if (cs_ni !== 1'b0) begin
      edge_cnt = 0;
      rwds_o <= 1'b0;
    end else if (ck_i !== ck_prev) begin
      if (edge_cnt < `HB_CA_BYTES) begin
        ca = {ca[39:0], dq_i};
        // Word address is the upper and lower address fields joined.
        addr = {ca[44:16], ca[2:0]};
      end else if (edge_cnt >= DATA_EDGE) begin
        data_idx = edge_cnt - DATA_EDGE;
        word     = read_word(addr + 32'(data_idx / 2));
        if (ca[47]) begin
          // Read: high byte first, RWDS toggles with each byte.
          dq_o   <= data_idx[0] ? word[7:0] : word[15:8];
          rwds_o <= ~rwds_o;
        end else if (!data_idx[0]) begin
          hi_byte = dq_i;
          hi_mask = rwds_i;
        end else begin
          // RWDS high masks a byte.
          if (!hi_mask) begin
            word[15:8] = hi_byte;
          end
          if (!rwds_i) begin
            word[7:0] = dq_i;
          end
          mem[addr + 32'(data_idx / 2)] = word;
        end
      end
      edge_cnt++;
    end
    ck_prev = ck_i;
  end

endmodule

// ==== tests/hyperbus_phy_tb.sv ====
// Testbench for the HyperBus PHY, checking random requests against two HyperRAM models.
module hyperbus_phy_tb
  import hyperbus_pkg::*;
();

  localparam int NR_CS       = 2;
  localparam int BURST_WIDTH = 12;
  localparam int N_READS     = 6;
  localparam int N_GROUPS    = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   trans_valid;
  logic                   trans_ready;
  logic [31:0]            trans_address;
  logic [NR_CS-1:0]       trans_cs;
  logic                   trans_write;
  logic [BURST_WIDTH-1:0] trans_burst;
  logic                   tx_valid;
  logic                   tx_ready;
  hb_word_t               tx_data;
  hb_strb_t               tx_strb;
  logic                   rx_valid;
  logic                   rx_ready;
  hb_word_t               rx_data;
  logic [NR_CS-1:0]       hyper_cs_n;
  logic                   hyper_ck;
  logic                   hyper_ck_n;
  logic                   hyper_rwds_o;
  logic                   hyper_rwds_i;
  logic                   hyper_rwds_oe;
  logic [7:0]             hyper_dq_i;
  logic [7:0]             hyper_dq_o;
  logic                   hyper_dq_oe;
  logic                   hyper_reset_n;
  logic [7:0]             m0_dq;
  logic [7:0]             m1_dq;
  logic                   m0_rwds;
  logic                   m1_rwds;

  // Transaction list, built before the run.
  logic        t_chip  [$];
  logic [31:0] t_addr  [$];
  logic        t_write [$];
  int          t_burst [$];

  // Reference memory, keyed by chip and word address.
  hb_word_t         ref_mem [logic [32:0]];
  int               word_errors = 0;
  int               cs_errors   = 0;
  int               ctrl_errors = 0;
  int               cycles      = 0;
  int               cycle_limit = 0;
  logic             busy;
  logic [NR_CS-1:0] cur_cs;

  hyperbus_phy #(
    .NR_CS       (NR_CS),
    .BURST_WIDTH (BURST_WIDTH)
  ) dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .trans_valid_i   (trans_valid),
    .trans_ready_o   (trans_ready),
    .trans_address_i (trans_address),
    .trans_cs_i      (trans_cs),
    .trans_write_i   (trans_write),
    .trans_burst_i   (trans_burst),
    .tx_valid_i      (tx_valid),
    .tx_ready_o      (tx_ready),
    .tx_data_i       (tx_data),
    .tx_strb_i       (tx_strb),
    .rx_valid_o      (rx_valid),
    .rx_ready_i      (rx_ready),
    .rx_data_o       (rx_data),
    .hyper_cs_no     (hyper_cs_n),
    .hyper_ck_o      (hyper_ck),
    .hyper_ck_no     (hyper_ck_n),
    .hyper_rwds_o    (hyper_rwds_o),
    .hyper_rwds_i    (hyper_rwds_i),
    .hyper_rwds_oe_o (hyper_rwds_oe),
    .hyper_dq_i      (hyper_dq_i),
    .hyper_dq_o      (hyper_dq_o),
    .hyper_dq_oe_o   (hyper_dq_oe),
    .hyper_reset_no  (hyper_reset_n)
  );

  hyperram_model #(.FILL_KEY(16'h5a3c)) u_ram0 (
    .ck_i   (hyper_ck),
    .cs_ni  (hyper_cs_n[0]),
    .dq_i   (hyper_dq_o),
    .rwds_i (hyper_rwds_o),
    .dq_o   (m0_dq),
    .rwds_o (m0_rwds)
  );

  hyperram_model #(.FILL_KEY(16'hc3a5)) u_ram1 (
    .ck_i   (hyper_ck),
    .cs_ni  (hyper_cs_n[1]),
    .dq_i   (hyper_dq_o),
    .rwds_i (hyper_rwds_o),
    .dq_o   (m1_dq),
    .rwds_o (m1_rwds)
  );

  // The selected chip drives the shared read pins.
  assign hyper_dq_i   = !hyper_cs_n[0] ? m0_dq : m1_dq;
  assign hyper_rwds_i = (!hyper_cs_n[0] & m0_rwds) | (!hyper_cs_n[1] & m1_rwds);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic hb_word_t fill_value(logic chip, logic [31:0] waddr);
    return waddr[15:0] ^ waddr[31:16] ^ (chip ? 16'hc3a5 : 16'h5a3c);
  endfunction

  function automatic hb_word_t ref_read(logic chip, logic [31:0] waddr);
    if (ref_mem.exists({chip, waddr})) begin
      return ref_mem[{chip, waddr}];
    end
    return fill_value(chip, waddr);
  endfunction

  function automatic void ref_write(logic chip, logic [31:0] waddr, hb_word_t data,
                                    hb_strb_t strb);
    hb_word_t w;
    w = ref_read(chip, waddr);
    if (strb[1]) begin
      w[15:8] = data[15:8];
    end
    if (strb[0]) begin
      w[7:0] = data[7:0];
    end
    ref_mem[{chip, waddr}] = w;
  endfunction

  function automatic logic [31:0] rand_addr();
    return ($urandom & 32'h00f0_0000) | (32'($urandom_range(0, 511)) << 1);
  endfunction

  function automatic void add_trans(logic chip, logic [31:0] addr, logic write, int burst);
    t_chip.push_back(chip);
    t_addr.push_back(addr);
    t_write.push_back(write);
    t_burst.push_back(burst);
  endfunction

  task automatic check_word(string name, hb_word_t exp, hb_word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_cs(string name, logic [NR_CS-1:0] exp, logic [NR_CS-1:0] act);
    if (act !== exp) begin
      cs_errors++;
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      ctrl_errors++;
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic finish_run(logic timed_out);
    $display("Errors: data %0d, chip select %0d, control %0d",
             word_errors, cs_errors, ctrl_errors);
    if (timed_out || (word_errors + cs_errors + ctrl_errors) != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      finish_run(1'b1);
    end
  end

  // Chip select is idle between transactions and one-hot low during one.
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (!busy) begin
        check_cs("hyper_cs_no", '1, hyper_cs_n);
      end else if (hyper_cs_n !== '1) begin
        check_cs("hyper_cs_no", ~cur_cs, hyper_cs_n);
      end
    end
  end

  task automatic send_words(logic chip, logic [31:0] waddr, int burst);
    hb_word_t data;
    hb_strb_t strb;
    int       w;
    for (w = 0; w < burst; w++) begin
      data = hb_word_t'($urandom);
      if ($urandom_range(0, 1) == 1) begin
        strb = 2'b11;
      end else begin
        strb = hb_strb_t'($urandom_range(0, 2));
      end
      // Random pause before the word is offered.
      while ($urandom_range(0, 3) == 0) begin
        @(negedge clk);
      end
      tx_valid = 1'b1;
      tx_data  = data;
      tx_strb  = strb;
      // The word is taken on the rising edge that follows a high tx_ready_o.
      while (!tx_ready) begin
        @(negedge clk);
      end
      ref_write(chip, waddr + w, data, strb);
      @(negedge clk);
      tx_valid = 1'b0;
    end
  endtask

  task automatic receive_words(logic chip, logic [31:0] waddr, int burst);
    int n;
    n = 0;
    while (n < burst) begin
      rx_ready = ($urandom_range(0, 3) != 0);
      if (rx_valid && rx_ready) begin
        check_word("rx_data_o", ref_read(chip, waddr + n), rx_data);
        n++;
      end
      @(negedge clk);
    end
    rx_ready = 1'b0;
  endtask

  task automatic run_trans(int i);
    logic [31:0] waddr;
    waddr            = t_addr[i] >> 1;
    busy             = 1'b1;
    cur_cs           = '0;
    cur_cs[t_chip[i]] = 1'b1;
    trans_valid      = 1'b1;
    trans_address    = t_addr[i];
    trans_cs         = cur_cs;
    trans_write      = t_write[i];
    trans_burst      = BURST_WIDTH'(t_burst[i]);
    while (!trans_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    trans_valid = 1'b0;
    if (t_write[i]) begin
      send_words(t_chip[i], waddr, t_burst[i]);
    end else begin
      receive_words(t_chip[i], waddr, t_burst[i]);
    end
    while (hyper_cs_n !== '1) begin
      @(negedge clk);
    end
    @(negedge clk);
    // No extra word may be left behind.
    check_bit("trans_ready_o", 1'b1, trans_ready);
    check_bit("rx_valid_o", 1'b0, rx_valid);
    check_bit("hyper_ck_o", 1'b0, hyper_ck);
    check_bit("hyper_ck_no", 1'b1, hyper_ck_n);
    busy = 1'b0;
  endtask

  initial begin
    int unsigned seed;
    int          i;
    int          total_words;
    logic        chip;
    logic [31:0] addr;
    int          burst;
    seed = 32'h7670_9849;
    void'($urandom(seed));
    rst_n         = 1'b0;
    trans_valid   = 1'b0;
    trans_address = '0;
    trans_cs      = '0;
    trans_write   = 1'b0;
    trans_burst   = '0;
    tx_valid      = 1'b0;
    tx_data       = '0;
    tx_strb       = '0;
    rx_ready      = 1'b0;
    busy          = 1'b0;
    cur_cs        = '0;

    // Plain reads from chip 0, then write, read back, and read of the other chip.
    for (i = 0; i < N_READS; i++) begin
      add_trans(1'b0, rand_addr(), 1'b0, $urandom_range(1, 16));
    end
    for (i = 0; i < N_GROUPS; i++) begin
      chip  = 1'($urandom_range(0, 1));
      addr  = rand_addr();
      burst = $urandom_range(1, 16);
      add_trans(chip, addr, 1'b1, burst);
      add_trans(chip, addr, 1'b0, burst);
      add_trans(~chip, addr, 1'b0, burst);
    end
    total_words = 0;
    for (i = 0; i < t_burst.size(); i++) begin
      total_words += t_burst[i];
    end
    cycle_limit = 40 * total_words + 30 * t_burst.size() + 20;

    repeat (5) @(negedge clk);
    check_bit("trans_ready_o", 1'b1, trans_ready);
    check_bit("tx_ready_o", 1'b0, tx_ready);
    check_bit("rx_valid_o", 1'b0, rx_valid);
    check_cs("hyper_cs_no", '1, hyper_cs_n);
    check_bit("hyper_dq_oe_o", 1'b0, hyper_dq_oe);
    check_bit("hyper_rwds_oe_o", 1'b0, hyper_rwds_oe);
    check_bit("hyper_ck_o", 1'b0, hyper_ck);
    check_bit("hyper_ck_no", 1'b1, hyper_ck_n);
    check_bit("hyper_reset_no", 1'b0, hyper_reset_n);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("hyper_reset_no", 1'b0, hyper_reset_n);
    @(negedge clk);
    check_bit("hyper_reset_no", 1'b1, hyper_reset_n);

    for (i = 0; i < t_burst.size(); i++) begin
      run_trans(i);
    end
    repeat (4) @(negedge clk);
    finish_run(1'b0);
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/hyperbus_pkg.sv
hdl/hyperbus_cmd_if.sv
hdl/hyperbus_cmd_decode.sv
hdl/hyperbus_bus_fsm.sv
hdl/hyperbus_rx_assemble.sv
hdl/hyperbus_phy.sv
tests/hyperram_model.sv
tests/hyperbus_phy_tb.sv

// ==== Bender.yml ====
package:
  name: hyperbus_phy

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/hyperbus_pkg.sv
      - hdl/hyperbus_cmd_if.sv
      - hdl/hyperbus_cmd_decode.sv
      - hdl/hyperbus_bus_fsm.sv
      - hdl/hyperbus_rx_assemble.sv
      - hdl/hyperbus_phy.sv
  - target: test
    files:
      - tests/hyperram_model.sv
      - tests/hyperbus_phy_tb.sv
